//--- rtl/pre_pkg.sv
package pre_pkg;

  // frame geometry
  localparam int PIX_W       = 8;
  localparam int IMG_W       = 32;
  localparam int IMG_H       = 32;
  localparam int PAD_W       = IMG_W + 2;      // one pad byte at each end
  localparam int ROW_W       = PAD_W * PIX_W;  // 272 bit row
  localparam int FRAME_WORDS = IMG_W * IMG_H;
  localparam int ADDR_W      = 10;
  localparam int ROW_IDX_W   = 6;

  // rows 0 and LAST_ROW are pad rows
  localparam logic [ROW_IDX_W-1:0] LAST_ROW = ROW_IDX_W'(IMG_H + 1);

  // APB register map
  localparam int APB_AW = 4;
  localparam int APB_DW = 32;

  localparam logic [APB_AW-1:0] REG_CTRL   = 4'h0;  // bit0 enable, bit1 switch
  localparam logic [APB_AW-1:0] REG_PAD    = 4'h4;  // pad value
  localparam logic [APB_AW-1:0] REG_STATUS = 4'h8;  // read only flags

  // status bit positions
  localparam int ST_WR_FULL  = 0;
  localparam int ST_RD_READY = 1;
  localparam int ST_WR_BANK  = 2;

  // row builder state codes
  localparam int ST_W = 3;

  localparam logic [ST_W-1:0] ST_IDLE = 3'd0;  // wait for a ready frame
  localparam logic [ST_W-1:0] ST_NEXT = 3'd1;  // start of next row
  localparam logic [ST_W-1:0] ST_READ = 3'd2;  // issuing pixel reads
  localparam logic [ST_W-1:0] ST_LAST = 3'd3;  // last read in flight
  localparam logic [ST_W-1:0] ST_OUT  = 3'd4;  // row valid, wait for ready

endpackage

//--- rtl/apb_cfg_regs.sv
`timescale 1ns/1ps

module apb_cfg_regs import pre_pkg::*; (
  input  logic              PEclk,
  input  logic              rst_n,
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [APB_DW-1:0] i_pwdata,
  input  logic              i_wr_full,
  input  logic              i_rd_ready,
  input  logic              i_wr_bank,
  output logic [APB_DW-1:0] o_prdata,
  output logic              o_pready,
  output logic              o_pslverr,
  output logic              o_enable,
  output logic [PIX_W-1:0]  o_pad_value,
  output logic              o_switch_req
);

  logic access;   // APB access phase
  logic map_hit;  // address is one of the three registers
  logic bad_xfer;
  logic wr_en;

  assign access   = i_psel & i_penable;
  assign map_hit  = (i_paddr == REG_CTRL) || (i_paddr == REG_PAD) || (i_paddr == REG_STATUS);
  assign bad_xfer = !map_hit || (i_pwrite && (i_paddr == REG_STATUS));
  assign wr_en    = access & i_pwrite & !bad_xfer;

  assign o_pready  = 1'b1;  // zero wait states
  assign o_pslverr = access & bad_xfer;

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      o_enable     <= 1'b0;
      o_pad_value  <= '0;
      o_switch_req <= 1'b0;
    end else begin
      o_switch_req <= wr_en && (i_paddr == REG_CTRL) && i_pwdata[1];  // one cycle pulse
      if (wr_en && (i_paddr == REG_CTRL)) begin
        o_enable <= i_pwdata[0];
      end
      if (wr_en && (i_paddr == REG_PAD)) begin
        o_pad_value <= i_pwdata[PIX_W-1:0];
      end
    end
  end

  // read mux, switch bit always reads back zero
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      REG_CTRL: o_prdata[0] = o_enable;
      REG_PAD:  o_prdata[PIX_W-1:0] = o_pad_value;
      REG_STATUS: begin
        o_prdata[ST_WR_FULL]  = i_wr_full;
        o_prdata[ST_RD_READY] = i_rd_ready;
        o_prdata[ST_WR_BANK]  = i_wr_bank;
      end
      default: o_prdata = '0;
    endcase
  end

  // APB never has two access phases in a row without wait states,
  // so a CTRL write can only pulse the switch for a single cycle
  a_switch_single: assert property (
    @(posedge PEclk) disable iff (!rst_n)
    o_switch_req |=> !o_switch_req
  );

endmodule

//--- rtl/pingpong_frame_buffer.sv
`timescale 1ns/1ps

module pingpong_frame_buffer import pre_pkg::*; (
  input  logic              PEclk,
  input  logic              rst_n,
  input  logic [PIX_W-1:0]  i_pix_data,
  input  logic              i_pix_vld,
  input  logic              i_switch_req,
  input  logic [ADDR_W-1:0] i_rd_addr,
  input  logic              i_rd_release,
  output logic [PIX_W-1:0]  o_rd_data,
  output logic              o_wr_full,
  output logic              o_rd_ready,
  output logic              o_wr_bank
);

  // both banks share one array and the index msb selects the bank
  logic [PIX_W-1:0] mem [0:2*FRAME_WORDS-1];

  logic [ADDR_W:0] wr_cnt;  // pixels written into the write bank
  logic            wr_en;
  logic            rd_free;
  logic            switch_ok;

  assign o_wr_full = (wr_cnt == (ADDR_W+1)'(FRAME_WORDS));
  assign wr_en     = i_pix_vld && !o_wr_full;  // drop pixels once full

  // read side is free when idle or handing back its bank this cycle
  assign rd_free   = !o_rd_ready || i_rd_release;
  assign switch_ok = i_switch_req && o_wr_full && rd_free;

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_bank  <= 1'b0;
      o_rd_ready <= 1'b0;
      wr_cnt     <= '0;
    end else if (switch_ok) begin
      o_wr_bank  <= ~o_wr_bank;  // full bank goes to the reader
      o_rd_ready <= 1'b1;
      wr_cnt     <= '0;
    end else begin
      if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (i_rd_release) begin
        o_rd_ready <= 1'b0;
      end
    end
  end

  // raster order writes go to the write bank and reads come from the other one
  always_ff @(posedge PEclk) begin
    if (wr_en) begin
      mem[{o_wr_bank, wr_cnt[ADDR_W-1:0]}] <= i_pix_data;
    end
    o_rd_data <= mem[{~o_wr_bank, i_rd_addr}];  // one cycle latency
  end

  // while the reader owns its bank the writer stays on the other one
  a_no_write_rd_bank: assert property (
    @(posedge PEclk) disable iff (!rst_n)
    (o_rd_ready && !i_rd_release) |=> $stable(o_wr_bank)
  );

  // row builder may only hand back a bank it actually owns
  a_release_ready: assert property (
    @(posedge PEclk) disable iff (!rst_n)
    i_rd_release |-> o_rd_ready
  );

endmodule

//--- rtl/padded_row_builder.sv
`timescale 1ns/1ps

module padded_row_builder import pre_pkg::*; (
  input  logic                 PEclk,
  input  logic                 rst_n,
  input  logic                 i_enable,
  input  logic [PIX_W-1:0]     i_pad_value,
  input  logic                 i_rd_ready,
  input  logic [PIX_W-1:0]     i_rd_data,
  input  logic                 i_row_ready,
  output logic [ADDR_W-1:0]    o_rd_addr,
  output logic                 o_rd_release,
  output logic [ROW_W-1:0]     o_row_data,
  output logic [ROW_IDX_W-1:0] o_row_idx,
  output logic                 o_row_vld
);

  logic [ST_W-1:0]      state;
  logic [ROW_IDX_W-1:0] col;       // pixel reads issued in this row
  logic                 cap_q;     // read data valid this cycle
  logic [ROW_W-1:0]     pad_fill;
  logic                 pad_row;

  assign pad_fill = {PAD_W{i_pad_value}};
  assign pad_row  = (o_row_idx == '0) || (o_row_idx == LAST_ROW);

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      col          <= '0;
      cap_q        <= 1'b0;
      o_rd_addr    <= '0;
      o_rd_release <= 1'b0;
      o_row_idx    <= '0;
      o_row_vld    <= 1'b0;
    end else begin
      o_rd_release <= 1'b0;
      cap_q        <= (state == ST_READ);
      case (state)
        ST_IDLE: begin
          // old bank still flagged ready while release is in flight
          if (i_enable && i_rd_ready && !o_rd_release) begin
            o_row_idx <= '0;
            o_rd_addr <= '0;
            o_row_vld <= 1'b1;  // row 0 is all pad
            state     <= ST_OUT;
          end
        end
        ST_NEXT: begin
          if (i_enable) begin
            if (pad_row) begin
              o_row_vld <= 1'b1;
              state     <= ST_OUT;
            end else begin
              col   <= '0;
              state <= ST_READ;
            end
          end
        end
        ST_READ: begin
          o_rd_addr <= o_rd_addr + 1'b1;  // frame is read contiguously
          col       <= col + 1'b1;
          if (col == ROW_IDX_W'(IMG_W - 1)) begin
            state <= ST_LAST;
          end
        end
        ST_LAST: begin
          o_row_vld <= 1'b1;
          state     <= ST_OUT;
        end
        ST_OUT: begin
          if (i_row_ready) begin
            o_row_vld <= 1'b0;
            if (o_row_idx == LAST_ROW) begin
              o_rd_release <= 1'b1;  // frame done, bank back to writer
              state        <= ST_IDLE;
            end else begin
              o_row_idx <= o_row_idx + 1'b1;
              state     <= ST_NEXT;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte 0 sits in the msbs, pixels shift in from the low end of the middle
  always_ff @(posedge PEclk) begin
    if ((state == ST_IDLE) || (state == ST_NEXT)) begin
      o_row_data <= pad_fill;
    end else if (cap_q) begin
      o_row_data[ROW_W-PIX_W-1:PIX_W] <= {o_row_data[ROW_W-2*PIX_W-1:PIX_W], i_rd_data};
    end
  end

  a_row_hold: assert property (
    @(posedge PEclk) disable iff (!rst_n)
    (o_row_vld && !i_row_ready) |=>
      (o_row_vld && $stable(o_row_data) && $stable(o_row_idx))
  );

endmodule

//--- rtl/input_pre_top.sv
`timescale 1ns/1ps

module input_pre_top import pre_pkg::*; (
  input  logic                 PEclk,
  input  logic                 rst_n,
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  logic [APB_AW-1:0]    i_paddr,
  input  logic [APB_DW-1:0]    i_pwdata,
  output logic [APB_DW-1:0]    o_prdata,
  output logic                 o_pready,
  output logic                 o_pslverr,
  input  logic [PIX_W-1:0]     i_pix_data,
  input  logic                 i_pix_vld,
  output logic [ROW_W-1:0]     o_row_data,
  output logic [ROW_IDX_W-1:0] o_row_idx,
  output logic                 o_row_vld,
  input  logic                 i_row_ready
);

  logic              enable;
  logic [PIX_W-1:0]  pad_value;
  logic              switch_req;
  logic              wr_full;
  logic              rd_ready;
  logic              wr_bank;
  logic [ADDR_W-1:0] rd_addr;
  logic [PIX_W-1:0]  rd_data;
  logic              rd_release;

  // decode
  apb_cfg_regs apb_cfg_regs_inst (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_wr_full    (wr_full),
    .i_rd_ready   (rd_ready),
    .i_wr_bank    (wr_bank),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .o_enable     (enable),
    .o_pad_value  (pad_value),
    .o_switch_req (switch_req)
  );

  // execute
  pingpong_frame_buffer pingpong_frame_buffer_inst (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_pix_data   (i_pix_data),
    .i_pix_vld    (i_pix_vld),
    .i_switch_req (switch_req),
    .i_rd_addr    (rd_addr),
    .i_rd_release (rd_release),
    .o_rd_data    (rd_data),
    .o_wr_full    (wr_full),
    .o_rd_ready   (rd_ready),
    .o_wr_bank    (wr_bank)
  );

  // result
  padded_row_builder padded_row_builder_inst (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_enable     (enable),
    .i_pad_value  (pad_value),
    .i_rd_ready   (rd_ready),
    .i_rd_data    (rd_data),
    .i_row_ready  (i_row_ready),
    .o_rd_addr    (rd_addr),
    .o_rd_release (rd_release),
    .o_row_data   (o_row_data),
    .o_row_idx    (o_row_idx),
    .o_row_vld    (o_row_vld)
  );

endmodule

//--- test/tb_input_pre.sv
`timescale 1ns/1ps

module tb_input_pre import pre_pkg::*; ();

  localparam int CLK_HALF     = 20;
  localparam int N_TESTS      = 6;
  localparam int ROW_WAIT     = 4 * IMG_W;
  // one load plus one padded readout with the longest stalls
  localparam int FRAME_CYCLES = FRAME_WORDS + PAD_W * (IMG_W + 16);
  localparam int WATCHDOG_NS  = (N_TESTS * 2 * FRAME_CYCLES + 100) * 2 * CLK_HALF;

  logic                 PEclk;
  logic                 rst_n;
  logic                 i_psel;
  logic                 i_penable;
  logic                 i_pwrite;
  logic [APB_AW-1:0]    i_paddr;
  logic [APB_DW-1:0]    i_pwdata;
  logic [APB_DW-1:0]    o_prdata;
  logic                 o_pready;
  logic                 o_pslverr;
  logic [PIX_W-1:0]     i_pix_data;
  logic                 i_pix_vld;
  logic [ROW_W-1:0]     o_row_data;
  logic [ROW_IDX_W-1:0] o_row_idx;
  logic                 o_row_vld;
  logic                 i_row_ready;

  logic [PIX_W-1:0] gold [0:1][0:FRAME_WORDS-1];  // pixels per bank
  logic [15:0]      lfsr;
  int               wr_slot = 0;  // mirrors the write bank
  int               rd_slot = 0;
  int               errors = 0;
  int               checks = 0;
  int               tests_run = 0;
  int               test_start_err = 0;
  string            cur_test;

  input_pre_top input_pre_top_inst (.*);

  initial begin
    PEclk = 1'b0;
    forever #CLK_HALF PEclk = ~PEclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // byte 0 is the msb with pad rows top and bottom and a pad byte at each end
  function automatic logic [ROW_W-1:0] expected_row(input int slot, input int r,
                                                    input logic [PIX_W-1:0] pad);
    logic [ROW_W-1:0] row;
    for (int b = 0; b < PAD_W; b++) begin
      if (r == 0 || r == IMG_H + 1 || b == 0 || b == PAD_W - 1)
        row[ROW_W-1-PIX_W*b -: PIX_W] = pad;
      else
        row[ROW_W-1-PIX_W*b -: PIX_W] = gold[slot][(r-1)*IMG_W + b - 1];
    end
    return row;
  endfunction

  task automatic check_val(input string what, input logic [ROW_W-1:0] exp,
                           input logic [ROW_W-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR %s: %s", cur_test, msg);
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_start_err = errors;
  endtask

  task automatic end_test;
    tests_run++;
    $display("test %s finished with %0d errors", cur_test, errors - test_start_err);
  endtask

  // setup phase then access phase sampled mid cycle
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    @(posedge PEclk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= wr;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge PEclk);
    i_penable <= 1'b1;
    @(negedge PEclk);
    rdata = o_prdata;
    err   = o_pslverr;
    @(posedge PEclk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic load_frame(input int slot);
    logic [15:0] v;
    for (int i = 0; i < FRAME_WORDS; i++) begin
      rand_bits(8, v);
      gold[slot][i] = v[PIX_W-1:0];
      @(posedge PEclk);
      i_pix_vld  <= 1'b1;
      i_pix_data <= v[PIX_W-1:0];
    end
    @(posedge PEclk);
    i_pix_vld <= 1'b0;
  endtask

  task automatic switch_banks(input logic en);
    logic [APB_DW-1:0] d;
    logic              err;
    apb_xfer(1'b1, REG_CTRL, {30'd0, 1'b1, en}, d, err);
    rd_slot = wr_slot;
    wr_slot = 1 - wr_slot;
  endtask

  task automatic wait_row_vld(output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < ROW_WAIT) begin
      @(negedge PEclk);
      ok = o_row_vld;
      n++;
    end
  endtask

  // takes all rows of a frame and optionally stalls each one
  task automatic collect_frame(input int slot, input logic [PIX_W-1:0] pad, input logic bp);
    logic                 ok;
    logic [ROW_W-1:0]     row_q;
    logic [ROW_IDX_W-1:0] idx_q;
    logic [15:0]          v;
    int                   hold;
    for (int r = 0; r < IMG_H + 2; r++) begin
      wait_row_vld(ok);
      if (!ok) begin
        check_true(1'b0, $sformatf("row %0d never became valid", r));
        return;
      end
      row_q = o_row_data;
      idx_q = o_row_idx;
      hold  = 0;
      if (bp) begin
        rand_bits(3, v);
        hold = int'(v[2:0]) + 1;
      end
      for (int k = 0; k < hold; k++) begin
        @(negedge PEclk);
        check_true(o_row_vld, "row valid dropped while stalled");
        check_val($sformatf("row %0d held data", r), row_q, o_row_data);
        check_val($sformatf("row %0d held index", r), ROW_W'(idx_q), ROW_W'(o_row_idx));
      end
      @(posedge PEclk);
      i_row_ready <= 1'b1;
      @(posedge PEclk);
      i_row_ready <= 1'b0;  // row taken on this edge
      check_val($sformatf("row %0d index", r), ROW_W'(r), ROW_W'(idx_q));
      check_val($sformatf("row %0d data", r), expected_row(slot, r, pad), row_q);
    end
  endtask

  task automatic test_apb_regs;
    logic [APB_DW-1:0] d;
    logic              err;
    start_test("apb_regs");
    apb_xfer(1'b1, REG_PAD, 32'h5a, d, err);
    apb_xfer(1'b0, REG_PAD, 32'h0, d, err);
    check_val("pad readback", ROW_W'(32'h5a), ROW_W'(d));
    check_true(!err && o_pready, "pad access was not a clean transfer");
    apb_xfer(1'b1, REG_CTRL, 32'h2, d, err);
    apb_xfer(1'b0, REG_CTRL, 32'h0, d, err);
    check_val("ctrl readback", ROW_W'(0), ROW_W'(d));  // switch bit reads zero
    apb_xfer(1'b0, 4'hc, 32'h0, d, err);
    check_true(err, "unmapped read gave no slave error");
    apb_xfer(1'b1, REG_STATUS, 32'h7, d, err);
    check_true(err, "status write gave no slave error");
    end_test;
  endtask

  task automatic test_refused_switch;
    logic [APB_DW-1:0] d;
    logic              err;
    start_test("refused_switch");
    apb_xfer(1'b1, REG_CTRL, 32'h2, d, err);
    apb_xfer(1'b0, REG_STATUS, 32'h0, d, err);
    check_val("status before full", ROW_W'(0), ROW_W'(d));
    load_frame(wr_slot);
    apb_xfer(1'b0, REG_STATUS, 32'h0, d, err);
    check_val("status when full", ROW_W'(1), ROW_W'(d));
    switch_banks(1'b0);
    apb_xfer(1'b0, REG_STATUS, 32'h0, d, err);
    check_val("status after switch", ROW_W'(6), ROW_W'(d));  // ready on bank 1
    end_test;
  endtask

  task automatic test_padded_frame;
    logic [APB_DW-1:0] d;
    logic              err;
    start_test("padded_frame");
    apb_xfer(1'b1, REG_CTRL, 32'h1, d, err);
    collect_frame(rd_slot, 8'h5a, 1'b0);
    apb_xfer(1'b0, REG_STATUS, 32'h0, d, err);
    check_val("status after frame", ROW_W'(4), ROW_W'(d));  // bank released, writer on 1
    end_test;
  endtask

  task automatic test_back_pressure;
    start_test("back_pressure");
    load_frame(wr_slot);
    switch_banks(1'b1);
    collect_frame(rd_slot, 8'h5a, 1'b1);
    end_test;
  endtask

  task automatic test_pingpong_overlap;
    logic [APB_DW-1:0] d;
    logic              err;
    start_test("pingpong_overlap");
    load_frame(wr_slot);
    switch_banks(1'b1);
    fork
      collect_frame(rd_slot, 8'h5a, 1'b0);
      load_frame(wr_slot);
    join
    apb_xfer(1'b1, REG_PAD, 32'hc3, d, err);
    switch_banks(1'b1);
    collect_frame(rd_slot, 8'hc3, 1'b0);
    end_test;
  endtask

  task automatic test_enable_gate;
    logic [APB_DW-1:0] d;
    logic              err;
    logic              seen;
    start_test("enable_gate");
    apb_xfer(1'b1, REG_CTRL, 32'h0, d, err);
    load_frame(wr_slot);
    switch_banks(1'b0);
    apb_xfer(1'b0, REG_STATUS, 32'h0, d, err);
    check_true(d[ST_RD_READY], "read bank not ready after switch");
    seen = 1'b0;
    repeat (100) begin
      @(negedge PEclk);
      seen = seen | o_row_vld;
    end
    check_true(!seen, "row valid rose while enable was low");
    apb_xfer(1'b1, REG_CTRL, 32'h1, d, err);
    collect_frame(rd_slot, 8'hc3, 1'b0);
    end_test;
  endtask

  initial begin
    rst_n       <= 1'b0;
    i_psel      <= 1'b0;
    i_penable   <= 1'b0;
    i_pwrite    <= 1'b0;
    i_paddr     <= '0;
    i_pwdata    <= '0;
    i_pix_data  <= '0;
    i_pix_vld   <= 1'b0;
    i_row_ready <= 1'b0;
    lfsr = 16'd24151;
    repeat (10) @(posedge PEclk);
    rst_n <= 1'b1;
    @(posedge PEclk);
    test_apb_regs;
    test_refused_switch;
    test_padded_frame;
    test_back_pressure;
    test_pingpong_overlap;
    test_enable_gate;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- all.f
rtl/pre_pkg.sv
rtl/apb_cfg_regs.sv
rtl/pingpong_frame_buffer.sv
rtl/padded_row_builder.sv
rtl/input_pre_top.sv
test/tb_input_pre.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_input_pre -f all.f -o tb_input_pre

./obj_dir/tb_input_pre | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run.sh: simulation reported pass"
  exit 0
fi
echo "run.sh: simulation did not report pass"
exit 1
